//--- hw/exec_pkg.sv
// ====================
// shared definitions for the execution pipeline
// opcode and size enums, instruction field layout
// register codes and their helpers
// flag bit positions and reset values
// ====================
`default_nettype none

package exec_pkg;

    typedef enum logic [3:0] {
        OP_NOP, OP_LD, OP_ADD, OP_ADC, OP_SUB, OP_CP, OP_AND, OP_OR,
        OP_XOR, OP_INC, OP_DEC, OP_LDRFP
    } op_e;

    typedef enum logic [1:0] {SZ_BYTE, SZ_WORD, SZ_LONG} size_e;

    typedef logic [7:0] reg_code_t; // [7] pointer, [5:2] acc index, [3:2] ptr index, [1:0] lane

    localparam int OP_MSB   = 31;
    localparam int OP_LSB   = 28;
    localparam int SIZE_MSB = 27;
    localparam int SIZE_LSB = 26;
    localparam int DST_MSB  = 25;
    localparam int DST_LSB  = 23;
    localparam int SRC_MSB  = 22;
    localparam int SRC_LSB  = 20;
    localparam int IMM_SEL  = 19;
    localparam int IMM_MSB  = 15;
    localparam int IMM_LSB  = 0;

    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_H = 4;
    localparam int FLAG_V = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 0;

    localparam logic [31:0] XSP_RESET = 32'h100;

    // byte codes split W/A style pairs, word and long take whole registers
    function automatic reg_code_t r3_code(input logic [2:0] r3, input size_e sz,
                                          input logic [1:0] bank);
        if (sz == SZ_BYTE)
            return {2'b00, bank, r3[2:1], 1'b0, ~r3[0]};
        else if (r3[2])
            return {4'b1000, r3[1:0], 2'b00}; // XIX..XSP
        else
            return {2'b00, bank, r3[1:0], 2'b00};
    endfunction

    // true when both codes land in the same 32-bit register
    function automatic logic same_reg(input reg_code_t x, input reg_code_t y);
        if (x[7] != y[7])
            return 1'b0;
        return x[7] ? (x[3:2] == y[3:2]) : (x[5:2] == y[5:2]);
    endfunction

    function automatic logic [31:0] size_mask(input size_e sz);
        case (sz)
            SZ_BYTE: return 32'h0000_00ff;
            SZ_WORD: return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic logic size_msb(input logic [31:0] v, input size_e sz);
        case (sz)
            SZ_BYTE: return v[7];
            SZ_WORD: return v[15];
            default: return v[31];
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hw/exec_ifs.sv
// ====================
// stage interfaces
// dec_if   decode to operand stage
// opnd_if  operand to execute stage
// rf_if    register file read and write ports
// ====================
`timescale 1ns/10ps
`default_nettype none

interface dec_if;
    import exec_pkg::*;

    logic        valid;
    op_e         op;
    size_e       size;
    reg_code_t   dst_code;
    reg_code_t   src_code;
    logic        use_imm;
    logic [15:0] imm;

    modport src (output valid, op, size, dst_code, src_code, use_imm, imm);
    modport dst (input valid, op, size, dst_code, src_code, use_imm, imm);
endinterface

interface opnd_if;
    import exec_pkg::*;

    logic        valid;
    op_e         op;
    size_e       size;
    reg_code_t   dst_code;
    logic [31:0] a;      // already lane aligned and zero extended
    logic [31:0] b;

    modport src (output valid, op, size, dst_code, a, b);
    modport dst (input valid, op, size, dst_code, a, b);
endinterface

interface rf_if;
    import exec_pkg::*;

    reg_code_t   rd_a;
    reg_code_t   rd_b;
    logic [31:0] q_a;   // full 32-bit register, not lane shifted
    logic [31:0] q_b;
    logic        we;
    reg_code_t   wr_code;
    size_e       wr_size;
    logic [31:0] wr_data;

    modport rf (input rd_a, rd_b, we, wr_code, wr_size, wr_data, output q_a, q_b);
    modport rd (output rd_a, rd_b, input q_a, q_b);
    modport wr (output we, wr_code, wr_size, wr_data);
endinterface

`default_nettype wire

//--- hw/decode_stage.sv
// ====================
// decode stage
// splits the instruction word, keeps the bank
// pointer and latches the register codes
// ====================
`timescale 1ns/10ps
`default_nettype none

module decode_stage #(
    parameter int NUM_BANKS = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr,
    input  logic        instr_valid,
    dec_if.src          dec,
    output logic [1:0]  rfp
);
    import exec_pkg::*;

    // bank count is a power of two, so wrapping is a mask
    localparam logic [1:0] BANK_WRAP = 2'(NUM_BANKS - 1);

    op_e        in_op;
    size_e      in_size;
    logic [2:0] in_dst;
    logic [2:0] in_src;
    logic       is_ldrfp;

    assign in_op    = op_e'(instr[OP_MSB:OP_LSB]);
    assign in_size  = size_e'(instr[SIZE_MSB:SIZE_LSB]);
    assign in_dst   = instr[DST_MSB:DST_LSB];
    assign in_src   = instr[SRC_MSB:SRC_LSB];
    assign is_ldrfp = instr_valid && (in_op == OP_LDRFP);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec.valid <= 1'b0;
            rfp       <= 2'd0;
        end else begin
            dec.valid <= instr_valid && !is_ldrfp; // LDRFP leaves a bubble
            if (is_ldrfp) begin
                rfp <= instr[IMM_LSB +: 2] & BANK_WRAP;
            end
        end
    end

    // codes use the bank in force when the instruction is sampled
    always_ff @(posedge clk) begin
        dec.op       <= in_op;
        dec.size     <= in_size;
        dec.dst_code <= r3_code(in_dst, in_size, rfp);
        dec.src_code <= r3_code(in_src, in_size, rfp);
        dec.use_imm  <= instr[IMM_SEL];
        dec.imm      <= instr[IMM_MSB:IMM_LSB];
    end

endmodule

`default_nettype wire

//--- hw/reg_file.sv
// ====================
// banked register file
// accumulators per bank and four pointers
// size aware partial writes with write-through
// byte wide dump port for state inspection
// ====================
`timescale 1ns/10ps
`default_nettype none

module reg_file #(
    parameter int NUM_BANKS = 4
) (
    input  logic       clk,
    input  logic       rst,
    rf_if.rf           rf,
    input  logic [1:0] rfp,
    input  logic [7:0] flags,
    input  logic [7:0] dmp_addr,
    output logic [7:0] dmp_dout
);
    import exec_pkg::*;

    localparam int NUM_ACCS = NUM_BANKS * 4;
    localparam int PTR_XSP  = 3;

    logic [31:0] accs [NUM_ACCS];
    logic [31:0] ptrs [4];

    logic [31:0] wr_old;
    logic [31:0] wr_merged;
    logic [31:0] stored_a;
    logic [31:0] stored_b;
    logic [31:0] dmp_word;

    // merge new data into the register being written
    always_comb begin
        wr_old    = rf.wr_code[7] ? ptrs[rf.wr_code[3:2]] : accs[rf.wr_code[5:2]];
        wr_merged = wr_old;
        case (rf.wr_size)
            SZ_BYTE: wr_merged[{rf.wr_code[1:0], 3'b000} +: 8] = rf.wr_data[7:0];
            SZ_WORD: wr_merged[15:0] = rf.wr_data[15:0];
            default: wr_merged = rf.wr_data;
        endcase
    end

    always_comb begin
        stored_a = rf.rd_a[7] ? ptrs[rf.rd_a[3:2]] : accs[rf.rd_a[5:2]];
        stored_b = rf.rd_b[7] ? ptrs[rf.rd_b[3:2]] : accs[rf.rd_b[5:2]];
    end

    // a read of the register under write sees the merged value
    assign rf.q_a = (rf.we && same_reg(rf.rd_a, rf.wr_code)) ? wr_merged : stored_a;
    assign rf.q_b = (rf.we && same_reg(rf.rd_b, rf.wr_code)) ? wr_merged : stored_b;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_ACCS; i++) begin
                accs[i] <= '0;
            end
            for (int i = 0; i < 4; i++) begin
                ptrs[i] <= (i == PTR_XSP) ? XSP_RESET : '0;
            end
        end else if (rf.we) begin
            if (rf.wr_code[7]) begin
                ptrs[rf.wr_code[3:2]] <= wr_merged;
            end else begin
                accs[rf.wr_code[5:2]] <= wr_merged;
            end
        end
    end

    // 0..63 accumulators, 64..79 pointers
    always_comb begin
        dmp_word = '0;
        if (dmp_addr < 8'd64) begin
            if (int'(dmp_addr[5:2]) < NUM_ACCS) begin
                dmp_word = accs[dmp_addr[5:2]]; // banks beyond NUM_BANKS read 0
            end
        end else if (dmp_addr < 8'd80) begin
            dmp_word = ptrs[dmp_addr[3:2]];
        end
    end

    assign dmp_dout = (dmp_addr == 8'd80) ? flags :
                      (dmp_addr == 8'd81) ? {6'd0, rfp} :
                                            dmp_word[{dmp_addr[1:0], 3'b000} +: 8];

endmodule

`default_nettype wire

//--- hw/operand_stage.sv
// ====================
// operand stage
// register file reads, lane extraction,
// size masking and immediate select
// ====================
`timescale 1ns/10ps
`default_nettype none

module operand_stage (
    input  logic clk,
    input  logic rst,
    dec_if.dst   dec,
    rf_if.rd     rf,
    opnd_if.src  opnd
);
    import exec_pkg::*;

    logic [31:0] mask;
    logic [31:0] lane_a;
    logic [31:0] lane_b;
    logic [31:0] imm_ext;

    // destination is also the first operand
    assign rf.rd_a = dec.dst_code;
    assign rf.rd_b = dec.src_code;

    assign mask    = size_mask(dec.size);
    assign imm_ext = {16'd0, dec.imm} & mask;

    // shift the addressed lane down to bit 0
    assign lane_a = (rf.q_a >> {dec.dst_code[1:0], 3'b000}) & mask;
    assign lane_b = dec.use_imm ? imm_ext
                                : (rf.q_b >> {dec.src_code[1:0], 3'b000}) & mask;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            opnd.valid <= 1'b0;
        end else begin
            opnd.valid <= dec.valid;
        end
    end

    always_ff @(posedge clk) begin
        opnd.op       <= dec.op;
        opnd.size     <= dec.size;
        opnd.dst_code <= dec.dst_code;
        opnd.a        <= lane_a;
        opnd.b        <= lane_b;
    end

endmodule

`default_nettype wire

//--- hw/alu_stage.sv
// ====================
// execute stage
// ALU at byte, word or long width
// flag register and write-back request
// done strobe and registered result
// ====================
`timescale 1ns/10ps
`default_nettype none

module alu_stage (
    input  logic        clk,
    input  logic        rst,
    opnd_if.dst         opnd,
    rf_if.wr            rf,
    output logic [7:0]  flags,
    output logic        done,
    output logic [31:0] result
);
    import exec_pkg::*;

    logic [31:0] b_eff;
    logic [32:0] raw;      // extra bit holds the long carry
    logic [31:0] res;
    logic        is_sub;
    logic        is_incdec;
    logic        half;
    logic        carry;
    logic        ovf;
    logic        a_top;
    logic        b_top;
    logic        r_top;
    logic [7:0]  flags_q;
    logic [7:0]  flags_nxt;

    assign is_incdec = (opnd.op == OP_INC) || (opnd.op == OP_DEC);
    assign is_sub    = (opnd.op == OP_SUB) || (opnd.op == OP_CP) || (opnd.op == OP_DEC);
    assign b_eff     = is_incdec ? 32'd1 : opnd.b;

    always_comb begin
        case (opnd.op)
            OP_LD:                 raw = {1'b0, opnd.b};
            OP_ADD, OP_INC:        raw = {1'b0, opnd.a} + {1'b0, b_eff};
            OP_ADC:                raw = {1'b0, opnd.a} + {1'b0, b_eff} + 33'(flags_q[FLAG_C]);
            OP_SUB, OP_CP, OP_DEC: raw = {1'b0, opnd.a} - {1'b0, b_eff};
            OP_AND:                raw = {1'b0, opnd.a & opnd.b};
            OP_OR:                 raw = {1'b0, opnd.a | opnd.b};
            OP_XOR:                raw = {1'b0, opnd.a ^ opnd.b};
            default:               raw = '0;
        endcase
        res = raw[31:0] & size_mask(opnd.size);
    end

    always_comb begin
        case (opnd.size)
            SZ_BYTE: carry = raw[8];
            SZ_WORD: carry = raw[16];
            default: carry = raw[32];
        endcase
    end

    assign half  = opnd.a[4] ^ b_eff[4] ^ raw[4]; // carry or borrow into bit 4
    assign a_top = size_msb(opnd.a, opnd.size);
    assign b_top = size_msb(b_eff, opnd.size);
    assign r_top = size_msb(res, opnd.size);
    assign ovf   = is_sub ? (a_top != b_top) && (r_top != a_top)
                          : (a_top == b_top) && (r_top != a_top);

    always_comb begin
        flags_nxt = flags_q;
        case (opnd.op)
            OP_ADD, OP_ADC, OP_SUB, OP_CP, OP_INC, OP_DEC: begin
                flags_nxt[FLAG_S] = r_top;
                flags_nxt[FLAG_Z] = (res == '0);
                flags_nxt[FLAG_H] = half;
                flags_nxt[FLAG_V] = ovf;
                flags_nxt[FLAG_N] = is_sub;
                if (!is_incdec) flags_nxt[FLAG_C] = carry; // INC/DEC keep C
            end
            OP_AND, OP_OR, OP_XOR: begin
                flags_nxt[FLAG_S] = r_top;
                flags_nxt[FLAG_Z] = (res == '0);
                flags_nxt[FLAG_H] = (opnd.op == OP_AND);
                flags_nxt[FLAG_V] = ~^res;   // even parity
                flags_nxt[FLAG_N] = 1'b0;
                flags_nxt[FLAG_C] = 1'b0;
            end
            default: ;                       // LD and NOP leave flags
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags_q <= 8'd0;
            done    <= 1'b0;
        end else begin
            if (opnd.valid) flags_q <= flags_nxt;
            done <= opnd.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (opnd.valid) result <= res;
    end

    assign flags      = flags_q;
    assign rf.we      = opnd.valid && (opnd.op != OP_CP) && (opnd.op != OP_NOP);
    assign rf.wr_code = opnd.dst_code;
    assign rf.wr_size = opnd.size;
    assign rf.wr_data = res;

endmodule

`default_nettype wire

//--- hw/exec_core.sv
// ====================
// execution core top level
// decode, operand and execute stages
// around the banked register file
// ====================
`timescale 1ns/10ps
`default_nettype none

module exec_core #(
    parameter int NUM_BANKS = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr,
    input  logic        instr_valid,
    output logic        done,
    output logic [31:0] result,
    output logic [7:0]  flags,
    input  logic [7:0]  dmp_addr,
    output logic [7:0]  dmp_dout
);

    logic [1:0] rfp;   // current bank, shown on the dump port

    dec_if  dec_bus ();
    opnd_if opnd_bus ();
    rf_if   rf_bus ();

    decode_stage #(.NUM_BANKS(NUM_BANKS)) u_decode (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .dec         (dec_bus.src),
        .rfp         (rfp)
    );

    operand_stage u_operand (
        .clk  (clk),
        .rst  (rst),
        .dec  (dec_bus.dst),
        .rf   (rf_bus.rd),
        .opnd (opnd_bus.src)
    );

    alu_stage u_alu (
        .clk    (clk),
        .rst    (rst),
        .opnd   (opnd_bus.dst),
        .rf     (rf_bus.wr),
        .flags  (flags),
        .done   (done),
        .result (result)
    );

    reg_file #(.NUM_BANKS(NUM_BANKS)) u_regs (
        .clk      (clk),
        .rst      (rst),
        .rf       (rf_bus.rf),
        .rfp      (rfp),
        .flags    (flags),
        .dmp_addr (dmp_addr),
        .dmp_dout (dmp_dout)
    );

endmodule

`default_nettype wire

//--- tests/clk_gen.sv
// ====================
// testbench clock and reset source
// 100 ns clock, reset held for 8 cycles
// ====================
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;    // release on a rising edge
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- tests/exec_core_properties.sv
// ====================
// concurrent checks on the core ports
// done latency, unused flag bits, reset quiet
// bound into every exec_core
// ====================
`timescale 1ns/10ps
`default_nettype none

module exec_core_properties (
    input logic       clk,
    input logic       rst,
    input logic       instr_valid,
    input logic       done,
    input logic [7:0] flags
);

    // sampled at E, done registered at E+2, seen at E+3
    done_latency: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(instr_valid, 3))
        else $error("done without an instruction sampled three cycles before");

    flag_gaps_zero: assert property (@(posedge clk) (flags[5] == 1'b0) && (flags[3] == 1'b0))
        else $error("flags bit 5 or bit 3 is set");

    done_low_in_reset: assert property (@(posedge clk) rst |-> !done)
        else $error("done is high during reset");

endmodule

bind exec_core exec_core_properties u_props (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .done        (done),
    .flags       (flags)
);

`default_nettype wire

//--- tests/tb_exec_core.sv
// ====================
// testbench for exec_core
// reads the cases file, issues instructions,
// checks done results, flags, latency and
// the register dump after reset and at the end
// ====================
`timescale 1ns/10ps
`default_nettype none

module tb_exec_core;
    import exec_pkg::*;

    localparam string CASES_FILE = "tests/exec_cases.txt";
    localparam int    DUMP_SPAN  = 82;   // register bytes, flags and bank pointer

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic        instr_valid;
    logic        done;
    logic [31:0] result;
    logic [7:0]  flags;
    logic [7:0]  dmp_addr;
    logic [7:0]  dmp_dout;

    string       rec_kind [$];   // T, I, B or D
    string       rec_name [$];
    logic [31:0] rec_a [$];
    logic [31:0] rec_b [$];
    logic [31:0] rec_c [$];

    logic [31:0] exp_result [$];  // in issue order
    logic [7:0]  exp_flags [$];
    int          exp_cycle [$];

    int seed    = 40;
    int cycles  = 0;
    int limit   = 100000;
    int passes  = 0;
    int errors  = 0;
    int n_instr = 0;
    int n_dump  = 0;

    clk_gen u_clk (.clk(clk), .rst(rst));

    exec_core #(.NUM_BANKS(4)) DUT (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .done        (done),
        .result      (result),
        .flags       (flags),
        .dmp_addr    (dmp_addr),
        .dmp_dout    (dmp_dout)
    );

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR t=%0t %s expected 0x%h got 0x%h", $time, name, expected, actual);
            errors++;
        end else begin
            passes++;
        end
    endtask

    task automatic read_cases();
        int          fd;
        int          n;
        int          fields;
        string       tag;
        string       text;
        logic [31:0] v0;
        logic [31:0] v1;
        logic [31:0] v2;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the cases file %s", CASES_FILE);
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            v0 = '0;
            v1 = '0;
            v2 = '0;
            text = "";
            if (tag == "#") begin
                n = $fgets(text, fd);   // rest of a comment line
                continue;
            end else if (tag == "T") begin
                fields = 1;
                n = $fscanf(fd, "%s", text);
            end else if (tag == "I" || tag == "B") begin
                fields = 3;
                n = $fscanf(fd, "%h %h %h", v0, v1, v2);
                n_instr++;
            end else if (tag == "D") begin
                fields = 2;
                n = $fscanf(fd, "%h %h", v0, v1);
                n_dump++;
            end else begin
                $display("unknown record %s in the cases file", tag);
                errors++;
                continue;
            end
            if (n != fields) begin
                $display("record %s in the cases file is missing a field", tag);
                errors++;
            end
            rec_kind.push_back(tag);
            rec_name.push_back(text);
            rec_a.push_back(v0);
            rec_b.push_back(v1);
            rec_c.push_back(v2);
        end
        $fclose(fd);
    endtask

    task automatic issue_instr(input logic [31:0] word, input logic [31:0] res,
                               input logic [7:0] flg, input bit gap);
        int idle;
        idle = gap ? int'($unsigned($random(seed)) % 3) : 0;
        repeat (idle) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
        @(posedge clk);
        instr       <= word;
        instr_valid <= 1'b1;
        if (word[31:28] != OP_LDRFP) begin   // bank switch leaves a bubble
            exp_result.push_back(res);
            exp_flags.push_back(flg);
            exp_cycle.push_back(cycles + 4);  // counter ticks at this edge too
        end
    endtask

    task automatic check_dump(input logic [7:0] addr, input logic [7:0] expected);
        @(posedge clk);
        instr_valid <= 1'b0;
        dmp_addr    <= addr;
        @(negedge clk);
        compare($sformatf("dmp_dout[%0d]", addr), 32'(expected), 32'(dmp_dout));
    endtask

    task automatic finish_test(input string name, input int err_start);
        @(posedge clk);
        instr_valid <= 1'b0;
        while (exp_result.size() != 0) begin
            @(negedge clk);
        end
        $display("test %s finished with %0d errors", name, errors - err_start);
    endtask

    // done pulses against the queued expectations
    always @(negedge clk) begin
        if (!rst && done) begin
            if (exp_result.size() == 0) begin
                $display("done pulse at %0t with no instruction in flight", $time);
                errors++;
            end else begin
                compare("result", exp_result.pop_front(), result);
                compare("flags", 32'(exp_flags.pop_front()), 32'(flags));
                compare("done cycle", exp_cycle.pop_front(), cycles);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout, the run did not end within %0d cycles", limit);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        string test_name;
        int    test_err;
        instr       = '0;
        instr_valid = 1'b0;
        dmp_addr    = '0;
        read_cases();
        limit = n_instr * 4 + n_dump + DUMP_SPAN + 50;
        @(negedge rst);

        test_err = errors;
        for (int a = 0; a < DUMP_SPAN; a++) begin
            check_dump(8'(a), (a == 77) ? 8'h01 : 8'h00);   // XSP resets to 0x100
        end
        $display("test reset_state finished with %0d errors", errors - test_err);

        test_name = "";
        for (int i = 0; i < rec_kind.size(); i++) begin
            if (rec_kind[i] == "T") begin
                if (test_name != "") begin
                    finish_test(test_name, test_err);
                end
                test_name = rec_name[i];
                test_err  = errors;
            end else if (rec_kind[i] == "D") begin
                check_dump(rec_a[i][7:0], rec_b[i][7:0]);
            end else begin
                issue_instr(rec_a[i], rec_b[i], rec_c[i][7:0], rec_kind[i] == "I");
            end
        end
        if (test_name != "") begin
            finish_test(test_name, test_err);
        end

        $display("checks passed %0d, errors %0d", passes, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/exec_cases.txt
# I|B <instr> <result> <flags>, all hex; B issues with no idle cycle before it
# D <dump addr> <byte>, hex; T <name> starts a test
T arith_byte
I 1088007f 0000007f 00   # ld.b a,0x7f
B 20880001 00000080 94   # add.b a,1
I 20880080 00000000 45
B 30880010 00000011 00   # adc.b takes C from the add
I 40880012 000000ff 93   # sub.b
I 508800ff 00000000 42   # cp.b, no write
I 1008005a 0000005a 42   # ld.b w
B 60800000 0000005a 14   # and.b a,w reads the new w
I 70880081 000000db 84
I 808800db 00000000 44
I a0800000 000000ff 92   # dec.b a
B 90800000 00000000 50   # inc.b a
T word_long
I 14881234 00001234 50   # ld.w bc
I 2488edcc 00000000 51
B 348800ff 00000100 10   # adc.w
I 1908beef 0000beef 10   # ld.l xde
B 49100000 0000bdef 02   # sub.l xde,xbc
I ab800000 000000ff 12   # dec.l xsp
I 5908ffff ffffbdf0 83   # cp.l xde
B 96000000 00000001 01   # inc.w ix keeps C
T partial
I 49880001 ffffffff 93   # sub.l xhl,1
I 15881234 00001234 93   # ld.w hl
B 13080000 00000000 93   # ld.b h
B 23e00000 00000034 00   # add.b l,h
T bank
I b0000001 00000000 00   # ldrfp 1
B 10880011 00000011 00
B 14882233 00002233 00
B 24800000 00002244 00   # add.w bc,wa in bank 1
I b0000006 00000000 00   # ldrfp 6 wraps to 2
B 13880077 00000077 00
B 53880078 000000ff 93
T final_dump
D 00 00 D 01 5a D 02 00 D 03 00
D 04 00 D 05 01
D 08 ef D 09 bd D 0a 00
D 0c 34 D 0d 00 D 0e ff D 0f ff
D 10 11 D 11 00 D 14 44 D 15 22
D 2c 77
D 40 01 D 41 00 D 4c ff D 4d 00
D 50 93 D 51 02

//--- src.f
hw/exec_pkg.sv
hw/exec_ifs.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/operand_stage.sv
hw/alu_stage.sv
hw/exec_core.sv
tests/clk_gen.sv
tests/exec_core_properties.sv
tests/tb_exec_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the exec_core testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_exec_core \
    -o tb_exec_core > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_exec_core > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Testbench failed" "$SIM_LOG"; then
    exit 1
fi
exit 0
